//--- sources.f
verilog/periph_pkg.sv
verilog/io_decode.sv
verilog/ems_mapper.sv
verilog/peripheral_sync.sv
verilog/bus_output_mux.sv
verilog/periph_top.sv
tests/periph_tb.sv

//--- tests/periph_tb.sv
////////////////////////////////////////////////////////////////////////////
// Self-checking testbench for the peripheral hub glue. Runs I/O bus cycles
// against periph_top, checks decode, EMS, LPT and synchronizer behavior
// with assertions and prints one line per test and a summary.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module periph_tb;
    import periph_pkg::*;

    localparam logic [15:0] EMS_PORT     = 16'h0260;
    localparam logic [15:0] LPT_PORT     = 16'h0378;
    localparam int          CLK_PERIOD   = 100;
    localparam int          SYNC_CYCLES  = 200;
    localparam int          TIMER_CYCLES = 1000;
    // Decode sweep, EMS writes, windows, EMS off, LPT, synchronizer
    localparam int TEST_CYCLES = 2 * 1024 + 24 * 2 + 5 + 64 + 8 + 20
                               + SYNC_CYCLES + 4 + TIMER_CYCLES + 1;
    localparam int WATCHDOG_CYCLES = 16 + TEST_CYCLES + 500;

    logic                 clock;
    logic                 reset;
    logic                 peripheral_clock;
    cpu_bus_t             bus;
    logic                 ems_enabled;
    logic [1:0]           ems_window;
    logic                 kbd_irq_in;
    logic [7:0]           keycode_in;
    logic                 dma_cs_n;
    logic                 pic_cs_n;
    logic                 pit_cs_n;
    logic                 ppi_cs_n;
    logic                 dma_page_cs_n;
    logic [3:0][6:0]      ems_map;
    ems_hit_t             ems_hit;
    logic                 timer_out;
    logic                 kbd_irq_out;
    logic [7:0]           keycode_out;
    logic [7:0]           data_out;
    logic                 from_chipset;

    logic [31:0]          lfsr_state;
    logic [3:0][6:0]      model_page;
    logic [3:0]           model_en;
    logic                 chipset_read;
    logic                 sync_check_on;
    logic                 count_ticks;
    int                   errors;
    int                   tests_run;
    int                   tests_failed;
    int                   periph_edges;

    periph_top #(
        .EMS_PORT (EMS_PORT),
        .LPT_PORT (LPT_PORT)
    ) periph_top_i (
        .clock               (clock),
        .reset               (reset),
        .peripheral_clock    (peripheral_clock),
        .bus_i               (bus),
        .ems_enabled_i       (ems_enabled),
        .ems_window_i        (ems_window),
        .kbd_irq_i           (kbd_irq_in),
        .keycode_i           (keycode_in),
        .dma_cs_n_o          (dma_cs_n),
        .pic_cs_n_o          (pic_cs_n),
        .pit_cs_n_o          (pit_cs_n),
        .ppi_cs_n_o          (ppi_cs_n),
        .dma_page_cs_n_o     (dma_page_cs_n),
        .ems_map_o           (ems_map),
        .ems_hit_o           (ems_hit),
        .timer_clock_o       (timer_out),
        .kbd_irq_o           (kbd_irq_out),
        .keycode_o           (keycode_out),
        .data_o              (data_out),
        .data_from_chipset_o (from_chipset)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    initial begin
        peripheral_clock = 1'b0;
        forever #70 peripheral_clock = ~peripheral_clock;
    end

    always @(posedge peripheral_clock) begin
        if (count_ticks) begin
            periph_edges++;
        end
    end

    task automatic report_error(input string message);
        errors++;
        $display("error at %0t ns: %s", $time, message);
    endtask

    function automatic logic lfsr_bit();
        logic feedback;
        feedback   = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], feedback};
        return feedback;
    endfunction

    function automatic logic [15:0] random_bits(input int count);
        logic [15:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[14:0], lfsr_bit()};
        end
        return value;
    endfunction

    function automatic logic in_port_range(input logic [15:0] port, input logic [15:0] base,
                                           input int span);
        return (port >= base) && (int'(port) < int'(base) + span);
    endfunction

    // Bit order is {dma_page, ppi, pit, pic, dma}
    function automatic logic [4:0] expected_selects(input logic [15:0] port, input logic aen_n);
        logic [4:0] selects;
        int         block;
        selects = 5'b11111;
        block   = (port % 256) / 32;
        if (!aen_n && (port % 1024) < 256 && block < 5) begin
            selects[block] = 1'b0;
        end
        return selects;
    endfunction

    function automatic logic [19:0] window_start(input logic [1:0] window, input int slot);
        logic [19:0] segment;
        segment = (window == 2'd0) ? 20'hA0000 : (window == 2'd1) ? 20'hC0000 : 20'hD0000;
        return segment + 20'(slot) * 20'h04000;
    endfunction

    function automatic ems_hit_t expected_hits(input logic [19:0] addr, input logic [1:0] window);
        ems_hit_t    hits;
        logic [19:0] start;
        for (int k = 0; k < EMS_SLOTS; k++) begin
            start   = window_start(window, k);
            hits[k] = model_en[k] && addr >= start && addr < start + 20'h04000;
        end
        return hits;
    endfunction

    function automatic logic [7:0] expected_readback(input logic [1:0] slot);
        return model_en[slot] ? {1'b0, model_page[slot]} : 8'hFF;
    endfunction

    task automatic model_write(input logic [1:0] slot, input logic [7:0] value);
        if (value == 8'hFF) begin
            model_page[slot] = 7'h7F;
            model_en[slot]   = 1'b0;
        end else if (value < 8'h80) begin
            model_page[slot] = value[6:0];
            model_en[slot]   = 1'b1;
        end
    endtask

    // Inputs change 5 ns after the rising edge
    task automatic next_cycle();
        @(posedge clock);
        #5;
    endtask

    task automatic bus_idle();
        bus.io_read_n  = 1'b1;
        bus.io_write_n = 1'b1;
        bus.aen_n      = 1'b1;
    endtask

    task automatic write_io(input logic [15:0] port, input logic [7:0] value);
        bus.addr       = {4'h0, port};
        bus.wdata      = value;
        bus.io_write_n = 1'b0;
        bus.aen_n      = 1'b0;
        next_cycle();
        bus_idle();
    endtask

    task automatic read_io(input logic [15:0] port, output logic [7:0] data, output logic flag);
        bus.addr      = {4'h0, port};
        bus.io_read_n = 1'b0;
        bus.aen_n     = 1'b0;
        @(negedge clock);
        data = data_out;
        flag = from_chipset;
        next_cycle();
        bus_idle();
    endtask

    task automatic close_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - errors_before);
        end
    endtask

    // Flag and data on the read bus follow the valid EMS and LPT reads
    assign chipset_read = !bus.io_read_n && !bus.aen_n
                        && ((ems_enabled && in_port_range(bus.addr[15:0], EMS_PORT, 4))
                            || in_port_range(bus.addr[15:0], LPT_PORT, 8));

    assert property (@(posedge clock) disable iff (reset)
        from_chipset == chipset_read && (chipset_read || data_out == 8'h00))
        else report_error($sformatf("read flag %0b data %02h at port %05h",
                                    from_chipset, data_out, bus.addr));

    assert property (@(posedge clock) disable iff (reset || !sync_check_on)
        keycode_out == $past(keycode_in, 2) && kbd_irq_out == $past(kbd_irq_in, 2))
        else report_error($sformatf("keycode %02h irq %0b do not match inputs two clocks back",
                                    keycode_out, kbd_irq_out));

    task automatic sweep_selects();
        logic [4:0] selects;
        for (int aen = 0; aen < 2; aen++) begin
            for (int port = 0; port < 1024; port++) begin
                bus.addr  = 20'(port);
                bus.aen_n = (aen == 1);
                @(negedge clock);
                selects = {dma_page_cs_n, ppi_cs_n, pit_cs_n, pic_cs_n, dma_cs_n};
                assert (selects == expected_selects(16'(port), aen == 1))
                    else report_error($sformatf("port %03h aen_n %0d gives selects %05b",
                                                port, aen, selects));
                next_cycle();
            end
        end
        bus_idle();
    endtask

    task automatic exercise_ems_registers();
        logic [1:0] slot;
        logic [7:0] value;
        logic [7:0] data;
        logic       flag;
        for (int i = 0; i < 24; i++) begin
            slot = 2'(random_bits(2));
            case (i % 5)
                0:       value = 8'(random_bits(7));
                2:       value = 8'h80 + 8'(random_bits(8) % 127);
                4:       value = 8'hFF;
                default: value = 8'(random_bits(8));
            endcase
            write_io(EMS_PORT + 16'(slot), value);
            model_write(slot, value);
            read_io(EMS_PORT + 16'(slot), data, flag);
            assert (flag && data == expected_readback(slot))
                else report_error($sformatf("slot %0d after %02h reads %02h, expected %02h",
                                            slot, value, data, expected_readback(slot)));
            assert (ems_map == model_page)
                else report_error($sformatf("page map %07h, expected %07h", ems_map, model_page));
        end
    endtask

    task automatic probe_ems_windows();
        logic [19:0] start;
        logic [19:0] addr;
        for (int k = 0; k < EMS_SLOTS; k++) begin
            write_io(EMS_PORT + 16'(k), 8'h10 + 8'(k));
            model_write(2'(k), 8'h10 + 8'(k));
        end
        // Slot 2 unmapped so the enable gating shows
        write_io(EMS_PORT + 16'd2, 8'hFF);
        model_write(2'd2, 8'hFF);
        for (int w = 0; w < 4; w++) begin
            for (int k = 0; k < EMS_SLOTS; k++) begin
                start = window_start(2'(w), k);
                for (int j = 0; j < 4; j++) begin
                    case (j)
                        0:       addr = start;
                        1:       addr = start + 20'(random_bits(14));
                        2:       addr = start + 20'h03FFF;
                        default: addr = start - 20'd1;
                    endcase
                    bus.addr   = addr;
                    ems_window = 2'(w);
                    @(negedge clock);
                    assert (ems_hit == expected_hits(addr, 2'(w)))
                        else report_error($sformatf("window %0d address %05h hits %04b",
                                                    w, addr, ems_hit));
                    next_cycle();
                end
            end
        end
    endtask

    task automatic write_with_ems_off();
        logic [7:0] data;
        logic       flag;
        ems_enabled = 1'b0;
        write_io(EMS_PORT, 8'h33);
        write_io(EMS_PORT + 16'd3, 8'hFF);
        assert (ems_map == model_page)
            else report_error($sformatf("page map changed to %07h with EMS off", ems_map));
        for (int k = 0; k < EMS_SLOTS; k++) begin
            read_io(EMS_PORT + 16'(k), data, flag);
            assert (!flag)
                else report_error($sformatf("EMS port %0d answered with EMS off", k));
        end
        ems_enabled = 1'b1;
    endtask

    task automatic exercise_lpt_port();
        logic [7:0] value;
        logic [7:0] data;
        logic       flag;
        read_io(LPT_PORT, data, flag);
        assert (flag && data == 8'hFF)
            else report_error($sformatf("LPT reads %02h after reset", data));
        for (int i = 0; i < 8; i++) begin
            value = 8'(random_bits(8));
            write_io(LPT_PORT + 16'(i), value);
            read_io(LPT_PORT + 16'(7 - i), data, flag);
            assert (flag && data == value)
                else report_error($sformatf("LPT reads %02h, expected %02h", data, value));
        end
        read_io(16'h03F8, data, flag);
        assert (!flag && data == 8'h00)
            else report_error($sformatf("port 3F8h answered with %02h", data));
        // Read strobe during a DMA cycle
        bus.addr      = {4'h0, LPT_PORT};
        bus.io_read_n = 1'b0;
        @(negedge clock);
        assert (!from_chipset)
            else report_error("LPT answered while AEN was high");
        next_cycle();
        bus_idle();
    endtask

    task automatic measure_synchronizer();
        int   rises;
        logic previous;
        sync_check_on = 1'b1;
        repeat (SYNC_CYCLES) begin
            keycode_in = 8'(random_bits(8));
            kbd_irq_in = lfsr_bit();
            next_cycle();
        end
        repeat (3) next_cycle();
        sync_check_on = 1'b0;
        rises        = 0;
        periph_edges = 0;
        count_ticks  = 1'b1;
        previous     = timer_out;
        repeat (TIMER_CYCLES) begin
            @(negedge clock);
            if (timer_out && !previous) begin
                rises++;
            end
            previous = timer_out;
        end
        count_ticks = 1'b0;
        next_cycle();
        assert (rises >= periph_edges / 2 - 1 && rises <= periph_edges / 2 + 1)
            else report_error($sformatf("%0d timer ticks over %0d peripheral clocks",
                                        rises, periph_edges));
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired, the tests did not finish within %0d cycles",
                 WATCHDOG_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        int errors_before;
        lfsr_state    = 32'hc21d;
        errors        = 0;
        tests_run     = 0;
        tests_failed  = 0;
        periph_edges  = 0;
        sync_check_on = 1'b0;
        count_ticks   = 1'b0;
        reset         = 1'b1;
        bus           = '0;
        bus_idle();
        ems_enabled   = 1'b1;
        ems_window    = 2'd0;
        kbd_irq_in    = 1'b0;
        keycode_in    = 8'h00;
        model_page    = '0;
        model_en      = '0;
        repeat (16) @(posedge clock);
        #5;
        reset = 1'b0;

        errors_before = errors;
        sweep_selects();
        close_test("chip-select decode", errors_before);
        errors_before = errors;
        exercise_ems_registers();
        close_test("EMS register writes", errors_before);
        errors_before = errors;
        probe_ems_windows();
        close_test("EMS window hits", errors_before);
        errors_before = errors;
        write_with_ems_off();
        close_test("EMS disabled", errors_before);
        errors_before = errors;
        exercise_lpt_port();
        close_test("LPT port", errors_before);
        errors_before = errors;
        measure_synchronizer();
        close_test("synchronizer", errors_before);

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/bus_output_mux.sv
////////////////////////////////////////////////////////////////////////////
// Printer data latch and the chipset read-data mux. EMS readback wins
// over the LPT latch; with no hit the bus is released with the
// from-chipset flag low.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module bus_output_mux (
    input  logic                          clock,
    input  logic                          reset,
    input  periph_pkg::cpu_bus_t          bus_i,
    input  logic                          lpt_hit_i,
    input  logic                          ems_hit_i,
    input  logic [periph_pkg::DATA_W-1:0] ems_rdata_i,
    output logic [periph_pkg::DATA_W-1:0] data_o,
    output logic                          data_from_chipset_o
);
    import periph_pkg::*;

    logic [DATA_W-1:0] lpt_q;
    logic              read_active;
    logic              lpt_write;

    // Hits are already qualified by AEN
    assign read_active = ~bus_i.io_read_n;
    assign lpt_write   = lpt_hit_i & ~bus_i.io_write_n;

    // Idle printer port reads as all ones
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            lpt_q <= '1;
        end else if (lpt_write) begin
            lpt_q <= bus_i.wdata;
        end
    end

    always_comb begin
        data_o              = '0;
        data_from_chipset_o = 1'b0;
        if (read_active && ems_hit_i) begin
            data_o              = ems_rdata_i;
            data_from_chipset_o = 1'b1;
        end else if (read_active && lpt_hit_i) begin
            data_o              = lpt_q;
            data_from_chipset_o = 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- verilog/ems_mapper.sv
////////////////////////////////////////////////////////////////////////////
// EMS page-map registers. Holds four page numbers with enables, flags CPU
// addresses inside the enabled 16 KB windows and returns the register
// addressed by the low port bits.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ems_mapper (
    input  logic                                                    clock,
    input  logic                                                    reset,
    input  periph_pkg::cpu_bus_t                                    bus_i,
    input  logic                                                    ems_hit_i,
    input  logic [1:0]                                              ems_window_i,
    output logic [periph_pkg::EMS_SLOTS*periph_pkg::EMS_PAGE_W-1:0] ems_map_o,
    output periph_pkg::ems_hit_t                                    ems_hit_o,
    output logic [periph_pkg::DATA_W-1:0]                           rdata_o
);
    import periph_pkg::*;

    localparam int SLOT_W = $clog2(EMS_SLOTS);

    logic [EMS_SLOTS-1:0][EMS_PAGE_W-1:0] page_q;
    logic [EMS_SLOTS-1:0]                 enable_q;
    ems_write_u                           wbyte;
    logic [SLOT_W-1:0]                    slot;
    logic                                 write_en;
    logic [3:0]                           window_base;

    assign wbyte.raw = bus_i.wdata;
    assign slot      = bus_i.addr[SLOT_W-1:0];

    // Hit already carries AEN and the EMS enable
    assign write_en = ems_hit_i & ~bus_i.io_write_n;

    // FFh unmaps, 00h-7Fh maps a page, 80h-FEh are ignored
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            page_q   <= '0;
            enable_q <= '0;
        end else if (write_en) begin
            if (wbyte.raw == '1) begin
                page_q[slot]   <= '1;
                enable_q[slot] <= 1'b0;
            end else if (!wbyte.map.ctrl) begin
                page_q[slot]   <= wbyte.map.page;
                enable_q[slot] <= 1'b1;
            end
        end
    end

    assign ems_map_o = page_q;

    // Upper nibble of the window base segment
    always_comb begin
        case (ems_window_i)
            2'd0:    window_base = 4'hA;
            2'd1:    window_base = 4'hC;
            default: window_base = 4'hD;
        endcase
    end

    // Slot n sits n x 16 KB above the base
    always_comb begin
        for (int n = 0; n < EMS_SLOTS; n++) begin
            ems_hit_o[n] = enable_q[n]
                         & (bus_i.addr[ADDR_W-1:14] == {window_base, SLOT_W'(n)});
        end
    end

    // Unmapped slots read back as FFh
    always_comb begin
        if (enable_q[slot]) begin
            rdata_o = DATA_W'(page_q[slot]);
        end else begin
            rdata_o = '1;
        end
    end

endmodule

`default_nettype wire

//--- verilog/io_decode.sv
////////////////////////////////////////////////////////////////////////////
// I/O address decoder. Splits ports 000h-0FFh into 32-port blocks for the
// XT chipset and flags hits on the EMS register and LPT data ports.
// Purely combinational, qualified by address enable.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module io_decode #(
    parameter logic [15:0] EMS_PORT = periph_pkg::EMS_PORT_DEFAULT,
    parameter logic [15:0] LPT_PORT = periph_pkg::LPT_PORT_DEFAULT
) (
    input  periph_pkg::cpu_bus_t   bus_i,
    input  logic                   ems_enabled_i,
    output periph_pkg::io_select_t sel_o
);

    logic       bus_active;
    logic       low_space;
    logic [4:0] block_n;
    logic       ems_match;
    logic       lpt_match;

    // CPU owns the bus only while AEN is low
    assign bus_active = ~bus_i.aen_n;
    assign low_space  = bus_active & (bus_i.addr[9:8] == 2'b00);

    // One active-low select per 32-port block
    always_comb begin
        block_n = 5'b11111;
        if (low_space) begin
            case (bus_i.addr[7:5])
                3'd0:    block_n = 5'b11110;
                3'd1:    block_n = 5'b11101;
                3'd2:    block_n = 5'b11011;
                3'd3:    block_n = 5'b10111;
                3'd4:    block_n = 5'b01111;
                // Blocks 5 to 7 belong to nothing here
                default: block_n = 5'b11111;
            endcase
        end
    end

    // EMS registers occupy four ports, LPT block eight
    assign ems_match = (bus_i.addr[15:2] == EMS_PORT[15:2]);
    assign lpt_match = (bus_i.addr[15:3] == LPT_PORT[15:3]);

    always_comb begin
        sel_o.dma_n      = block_n[0];
        sel_o.pic_n      = block_n[1];
        sel_o.pit_n      = block_n[2];
        sel_o.ppi_n      = block_n[3];
        sel_o.dma_page_n = block_n[4];
        sel_o.ems_hit    = bus_active & ems_enabled_i & ems_match;
        sel_o.lpt_hit    = bus_active & lpt_match;
    end

endmodule

`default_nettype wire

//--- verilog/periph_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Shared widths, default port bases and bus types for the peripheral hub
// glue. Modules import this package in their body and use scoped names
// in their port lists.
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package periph_pkg;

    // Bus widths
    parameter int ADDR_W     = 20;
    parameter int DATA_W     = 8;
    parameter int EMS_PAGE_W = 7;
    parameter int EMS_SLOTS  = 4;

    // Default I/O port bases
    parameter logic [15:0] EMS_PORT_DEFAULT = 16'h0260;
    parameter logic [15:0] LPT_PORT_DEFAULT = 16'h0378;

    // CPU bus as seen by the hub, strobes active low
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic              io_read_n;
        logic              io_write_n;
        logic              aen_n;
    } cpu_bus_t;

    // Decoder results, chip selects active low and port hits active high
    typedef struct packed {
        logic dma_n;
        logic pic_n;
        logic pit_n;
        logic ppi_n;
        logic dma_page_n;
        logic ems_hit;
        logic lpt_hit;
    } io_select_t;

    // Byte written to an EMS page-map register
    typedef union packed {
        logic [DATA_W-1:0] raw;
        struct packed {
            logic                  ctrl;
            logic [EMS_PAGE_W-1:0] page;
        } map;
    } ems_write_u;

    // One flag per EMS window
    typedef logic [EMS_SLOTS-1:0] ems_hit_t;

endpackage

`default_nettype wire

//--- verilog/periph_top.sv
////////////////////////////////////////////////////////////////////////////
// Top of the peripheral hub glue. Connects the I/O decoder, EMS mapper,
// clock-domain synchronizer and read-data mux; port bases are set here
// and passed down.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module periph_top #(
    parameter logic [15:0] EMS_PORT = periph_pkg::EMS_PORT_DEFAULT,
    parameter logic [15:0] LPT_PORT = periph_pkg::LPT_PORT_DEFAULT
) (
    input  logic                                                    clock,
    input  logic                                                    reset,
    input  logic                                                    peripheral_clock,
    input  periph_pkg::cpu_bus_t                                    bus_i,
    input  logic                                                    ems_enabled_i,
    input  logic [1:0]                                              ems_window_i,
    input  logic                                                    kbd_irq_i,
    input  logic [periph_pkg::DATA_W-1:0]                           keycode_i,
    output logic                                                    dma_cs_n_o,
    output logic                                                    pic_cs_n_o,
    output logic                                                    pit_cs_n_o,
    output logic                                                    ppi_cs_n_o,
    output logic                                                    dma_page_cs_n_o,
    output logic [periph_pkg::EMS_SLOTS*periph_pkg::EMS_PAGE_W-1:0] ems_map_o,
    output periph_pkg::ems_hit_t                                    ems_hit_o,
    output logic                                                    timer_clock_o,
    output logic                                                    kbd_irq_o,
    output logic [periph_pkg::DATA_W-1:0]                           keycode_o,
    output logic [periph_pkg::DATA_W-1:0]                           data_o,
    output logic                                                    data_from_chipset_o
);
    import periph_pkg::*;

    io_select_t        sel;
    logic [DATA_W-1:0] ems_rdata;

    io_decode #(
        .EMS_PORT (EMS_PORT),
        .LPT_PORT (LPT_PORT)
    ) io_decode_i (
        .bus_i         (bus_i),
        .ems_enabled_i (ems_enabled_i),
        .sel_o         (sel)
    );

    // Chipset selects leave the block untouched
    assign dma_cs_n_o      = sel.dma_n;
    assign pic_cs_n_o      = sel.pic_n;
    assign pit_cs_n_o      = sel.pit_n;
    assign ppi_cs_n_o      = sel.ppi_n;
    assign dma_page_cs_n_o = sel.dma_page_n;

    ems_mapper ems_mapper_i (
        .clock        (clock),
        .reset        (reset),
        .bus_i        (bus_i),
        .ems_hit_i    (sel.ems_hit),
        .ems_window_i (ems_window_i),
        .ems_map_o    (ems_map_o),
        .ems_hit_o    (ems_hit_o),
        .rdata_o      (ems_rdata)
    );

    peripheral_sync peripheral_sync_i (
        .clock            (clock),
        .reset            (reset),
        .peripheral_clock (peripheral_clock),
        .kbd_irq_i        (kbd_irq_i),
        .keycode_i        (keycode_i),
        .timer_clock_o    (timer_clock_o),
        .kbd_irq_o        (kbd_irq_o),
        .keycode_o        (keycode_o)
    );

    bus_output_mux bus_output_mux_i (
        .clock               (clock),
        .reset               (reset),
        .bus_i               (bus_i),
        .lpt_hit_i           (sel.lpt_hit),
        .ems_hit_i           (sel.ems_hit),
        .ems_rdata_i         (ems_rdata),
        .data_o              (data_o),
        .data_from_chipset_o (data_from_chipset_o)
    );

endmodule

`default_nettype wire

//--- verilog/peripheral_sync.sv
////////////////////////////////////////////////////////////////////////////
// Brings the timer tick and keyboard interrupt and keycode into the system
// clock domain. Tick is a half-rate toggle of the peripheral clock, all
// three signals pass two system clock registers.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module peripheral_sync (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          peripheral_clock,
    input  logic                          kbd_irq_i,
    input  logic [periph_pkg::DATA_W-1:0] keycode_i,
    output logic                          timer_clock_o,
    output logic                          kbd_irq_o,
    output logic [periph_pkg::DATA_W-1:0] keycode_o
);
    import periph_pkg::*;

    // Everything moving into the system domain together
    typedef struct packed {
        logic              timer;
        logic              irq;
        logic [DATA_W-1:0] keycode;
    } sync_word_t;

    logic       timer_toggle;
    sync_word_t sample;
    sync_word_t stage1_q;
    sync_word_t stage2_q;

    // Each peripheral clock edge flips the tick
    always_ff @(posedge peripheral_clock or posedge reset) begin
        if (reset) begin
            timer_toggle <= 1'b0;
        end else begin
            timer_toggle <= ~timer_toggle;
        end
    end

    assign sample.timer   = timer_toggle;
    assign sample.irq     = kbd_irq_i;
    assign sample.keycode = keycode_i;

    // Two-flop synchronizer for the tick, plain pipeline for keyboard data
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            stage1_q <= '0;
            stage2_q <= '0;
        end else begin
            stage1_q <= sample;
            stage2_q <= stage1_q;
        end
    end

    assign timer_clock_o = stage2_q.timer;
    assign kbd_irq_o     = stage2_q.irq;
    assign keycode_o     = stage2_q.keycode;

endmodule

`default_nettype wire
